/* fe_top.f */
+incdir+hdl
+incdir+tests
hdl/fe_pkg.sv
hdl/fe_controller.sv
hdl/fe_pc_gen.sv
hdl/fe_imem.sv
hdl/fe_queue_builder.sv
hdl/fe_top.sv
tests/tb_fe_top.sv

/* hdl/fe_consts.svh */
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// Fetch address and instruction word widths
`define FE_VADDR_WIDTH 16
`define FE_INSTR_WIDTH 32

// Instruction store geometry, one valid bit per word
`define FE_IMEM_WORDS 64
`define FE_IMEM_INDEX_WIDTH 6

// First legal fetch address, window is FE_IMEM_WORDS words long
`define FE_IMEM_BASE 16'h1000

// Exception cause field
`define FE_ECODE_WIDTH 2

`endif

/* hdl/fe_controller.sv */
`timescale 1ns/1ns

`include "fe_consts.svh"

module fe_controller
  (input                                clk_i
   , input                              reset_i

   , input  fe_pkg::fe_cmd_s            fe_cmd_i
   , input                              fe_cmd_v_i
   , output logic                       fe_cmd_yumi_o

   , input                              exception_v_i
   , input                              fetch_fail_i
   , input        [`FE_VADDR_WIDTH-1:0] if2_pc_i
   , input                              fe_queue_ready_i

   , output logic                       redirect_v_o
   , output logic [`FE_VADDR_WIDTH-1:0] redirect_pc_o
   , output logic                       advance_o
   , output logic                       poison_o
   , output logic                       block_o

   , output logic                       imem_clear_o
   , output logic                       imem_write_v_o
   , output logic [`FE_VADDR_WIDTH-1:0] imem_write_addr_o
   , output logic [`FE_INSTR_WIDTH-1:0] imem_write_instr_o
   );

  import fe_pkg::*;

  fe_state_e                  state_n, state_r;
  logic [`FE_VADDR_WIDTH-1:0] pc_resume_n, pc_resume_r;
  logic                       unstall;

  // Every command is taken the cycle it shows up
  assign fe_cmd_yumi_o = fe_cmd_v_i;
  assign block_o       = fe_cmd_v_i;

  always_comb
  begin
    imem_clear_o   = 1'b0;
    imem_write_v_o = 1'b0;
    if (fe_cmd_v_i)
    begin
      case (fe_cmd_i.opcode)
        e_op_state_reset: imem_clear_o   = 1'b1;
        e_op_icache_fill: imem_write_v_o = 1'b1;
        // Plain redirect only moves the PC
        default:          imem_write_v_o = 1'b0;
      endcase
    end
  end

  assign imem_write_addr_o  = fe_cmd_i.vaddr;
  assign imem_write_instr_o = fe_cmd_i.instr;

  always_comb
  begin
    state_n   = state_r;
    advance_o = 1'b0;
    poison_o  = 1'b0;
    unstall   = 1'b0;
    if (fe_cmd_v_i)
    begin
      state_n   = e_run;
      advance_o = 1'b1;
      poison_o  = 1'b1;
    end
    else
    begin
      case (state_r)
        e_run:
          if (exception_v_i)
          begin
            state_n  = e_wait;
            poison_o = 1'b1;
          end
          else if (fetch_fail_i)
          begin
            state_n  = e_stall;
            poison_o = 1'b1;
          end
          else
            advance_o = 1'b1;
        // Empty pipeline restarts once the queue is ready
        e_stall:
          if (fe_queue_ready_i)
          begin
            state_n   = e_run;
            advance_o = 1'b1;
            unstall   = 1'b1;
          end
        e_wait:
          state_n = e_wait;
        default:
          state_n = e_wait;
      endcase
    end
  end

  // Command vaddr bypasses the register so the redirect is same-cycle
  assign pc_resume_n   = fe_cmd_v_i ? fe_cmd_i.vaddr : if2_pc_i;
  assign redirect_v_o  = fe_cmd_v_i | unstall;
  assign redirect_pc_o = fe_cmd_v_i ? fe_cmd_i.vaddr : pc_resume_r;

  always_ff @(posedge clk_i)
  begin
    if (fe_cmd_v_i | fetch_fail_i)
      pc_resume_r <= pc_resume_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_wait;
    else
      state_r <= state_n;
  end

  a_cmd_opcode_known: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_yumi_o |-> (fe_cmd_i.opcode inside {e_op_state_reset, e_op_pc_redirect,
                                                e_op_icache_fill}))
    else $error("Command accepted with an undefined opcode");

endmodule

/* hdl/fe_imem.sv */
`timescale 1ns/1ns

`include "fe_consts.svh"

module fe_imem
  (input                                clk_i
   , input                              reset_i

   , input        [`FE_VADDR_WIDTH-1:0] read_pc_i
   , input                              clear_i
   , input                              write_v_i
   , input        [`FE_VADDR_WIDTH-1:0] write_addr_i
   , input        [`FE_INSTR_WIDTH-1:0] write_instr_i

   , output logic [`FE_INSTR_WIDTH-1:0] instr_o
   , output logic                       hit_o
   , output logic                       fault_o
   );

  import fe_pkg::*;

  localparam logic [`FE_VADDR_WIDTH-1:0] window_bytes = `FE_IMEM_WORDS * 4;

  function automatic logic in_window(input logic [`FE_VADDR_WIDTH-1:0] addr);
    logic [`FE_VADDR_WIDTH-1:0] offset;
    offset = addr - `FE_IMEM_BASE;
    return (addr >= `FE_IMEM_BASE) && (offset < window_bytes) && (addr[1:0] == 2'b00);
  endfunction

  logic [`FE_INSTR_WIDTH-1:0]     mem_r [`FE_IMEM_WORDS];
  logic [`FE_IMEM_WORDS-1:0]      word_v_r;
  logic [`FE_VADDR_WIDTH-1:0]     read_offset, write_offset;
  logic [`FE_IMEM_INDEX_WIDTH-1:0] read_idx, write_idx;
  logic                           read_ok, write_en, bypass;
  logic [`FE_INSTR_WIDTH-1:0]     s1_instr_r, s2_instr_r;
  logic                           s1_hit_r, s2_hit_r, s1_fault_r, s2_fault_r;

  assign read_offset  = read_pc_i - `FE_IMEM_BASE;
  assign write_offset = write_addr_i - `FE_IMEM_BASE;
  assign read_idx     = read_offset[`FE_IMEM_INDEX_WIDTH+1:2];
  assign write_idx    = write_offset[`FE_IMEM_INDEX_WIDTH+1:2];
  assign read_ok      = in_window(read_pc_i);
  assign write_en     = write_v_i & in_window(write_addr_i);

  // A fill is visible to the fetch issued in the same cycle
  assign bypass = write_en & (write_idx == read_idx);

  always_ff @(posedge clk_i)
  begin
    if (write_en)
      mem_r[write_idx] <= write_instr_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i | clear_i)
      word_v_r <= '0;
    else if (write_en)
      word_v_r[write_idx] <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    s1_instr_r <= bypass ? write_instr_i : mem_r[read_idx];
    s1_hit_r   <= ~clear_i & (bypass | word_v_r[read_idx]);
    s1_fault_r <= ~read_ok;
    s2_instr_r <= s1_instr_r;
    s2_hit_r   <= s1_hit_r;
    s2_fault_r <= s1_fault_r;
  end

  assign instr_o = s2_instr_r;
  assign hit_o   = s2_hit_r;
  assign fault_o = s2_fault_r;

  a_no_write_on_clear: assert property (@(posedge clk_i) disable iff (reset_i)
    !(write_v_i && clear_i))
    else $error("Store write and clear in the same cycle");

endmodule

/* hdl/fe_pc_gen.sv */
`timescale 1ns/1ns

`include "fe_consts.svh"

module fe_pc_gen
  (input                                clk_i
   , input                              reset_i

   , input                              redirect_v_i
   , input        [`FE_VADDR_WIDTH-1:0] redirect_pc_i
   , input                              advance_i
   , input                              poison_i

   , output logic [`FE_VADDR_WIDTH-1:0] next_pc_o
   , output logic                       if2_v_o
   , output logic [`FE_VADDR_WIDTH-1:0] if2_pc_o
   );

  import fe_pkg::*;

  localparam logic [`FE_VADDR_WIDTH-1:0] pc_step = 4;

  logic [`FE_VADDR_WIDTH-1:0] next_pc_r;
  logic [`FE_VADDR_WIDTH-1:0] if1_pc_r, if2_pc_r;
  logic                       if1_v_r, if2_v_r;

  // PC issued to the store this cycle
  assign next_pc_o = redirect_v_i ? redirect_pc_i : next_pc_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      next_pc_r <= `FE_IMEM_BASE;
    else if (advance_i)
      next_pc_r <= next_pc_o + pc_step;
    else
      next_pc_r <= next_pc_o;
  end

  // Poison drops whatever sits in IF1
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      if1_v_r <= 1'b0;
      if2_v_r <= 1'b0;
    end
    else
    begin
      if1_v_r <= advance_i;
      if2_v_r <= if1_v_r & ~poison_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if1_pc_r <= next_pc_o;
    if2_pc_r <= if1_pc_r;
  end

  assign if2_v_o  = if2_v_r;
  assign if2_pc_o = if2_pc_r;

  a_if1_follows_if2: assert property (@(posedge clk_i) disable iff (reset_i)
    (if1_v_r && if2_v_r) |-> (if1_pc_r == if2_pc_r + pc_step))
    else $error("Back-to-back IF1 and IF2 PCs are not one word apart");

endmodule

/* hdl/fe_pkg.sv */
`include "fe_consts.svh"

package fe_pkg;

  // Commands from the back end
  typedef enum logic [1:0]
  {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_icache_fill = 2'd2
  } fe_cmd_opcode_e;

  // Instr is only meaningful for a fill
  typedef struct packed
  {
    fe_cmd_opcode_e              opcode;
    logic [`FE_VADDR_WIDTH-1:0]  vaddr;
    logic [`FE_INSTR_WIDTH-1:0]  instr;
  } fe_cmd_s;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [`FE_ECODE_WIDTH-1:0]
  {
    e_instr_access_fault = 2'd0,
    e_icache_miss        = 2'd1
  } fe_exception_code_e;

  typedef struct packed
  {
    logic [`FE_INSTR_WIDTH-`FE_ECODE_WIDTH-1:0] pad;
    fe_exception_code_e                          code;
  } fe_exception_payload_s;

  // Same word, read by msg_type
  typedef union packed
  {
    logic [`FE_INSTR_WIDTH-1:0] instr;
    fe_exception_payload_s      exception;
  } fe_queue_payload_u;

  typedef struct packed
  {
    fe_msg_type_e                msg_type;
    logic [`FE_VADDR_WIDTH-1:0]  pc;
    fe_queue_payload_u           payload;
  } fe_queue_s;

  typedef enum logic [1:0] {e_wait = 2'd0, e_run, e_stall} fe_state_e;

endpackage

/* hdl/fe_queue_builder.sv */
`timescale 1ns/1ns

`include "fe_consts.svh"

module fe_queue_builder
  (input                                if2_v_i
   , input        [`FE_VADDR_WIDTH-1:0] if2_pc_i
   , input        [`FE_INSTR_WIDTH-1:0] instr_i
   , input                              hit_i
   , input                              fault_i
   , input                              block_i
   , input                              fe_queue_ready_i

   , output fe_pkg::fe_queue_s          fe_queue_o
   , output logic                       fe_queue_v_o
   , output logic                       exception_v_o
   , output logic                       fetch_fail_o
   );

  import fe_pkg::*;

  logic               is_exception;
  fe_exception_code_e ecode;

  // Access fault outranks a miss
  assign is_exception = fault_i | ~hit_i;
  assign ecode        = fault_i ? e_instr_access_fault : e_icache_miss;

  always_comb
  begin
    fe_queue_o.pc = if2_pc_i;
    if (is_exception)
    begin
      fe_queue_o.msg_type               = e_fe_exception;
      fe_queue_o.payload.exception.pad  = '0;
      fe_queue_o.payload.exception.code = ecode;
    end
    else
    begin
      fe_queue_o.msg_type      = e_fe_fetch;
      fe_queue_o.payload.instr = instr_i;
    end
  end

  assign fe_queue_v_o  = if2_v_i & fe_queue_ready_i & ~block_i;
  assign exception_v_o = fe_queue_v_o & is_exception;

  // Anything in IF2 that does not leave this cycle has to be refetched
  assign fetch_fail_o = if2_v_i & ~fe_queue_v_o;

endmodule

/* hdl/fe_top.sv */
`timescale 1ns/1ns

`include "fe_consts.svh"

module fe_top
  (input                       clk_i
   , input                     reset_i

   , input  fe_pkg::fe_cmd_s   fe_cmd_i
   , input                     fe_cmd_v_i
   , output logic              fe_cmd_yumi_o

   , output fe_pkg::fe_queue_s fe_queue_o
   , output logic              fe_queue_v_o
   , input                     fe_queue_ready_i
   );

  import fe_pkg::*;

  logic                       redirect_v, advance, poison, block;
  logic [`FE_VADDR_WIDTH-1:0] redirect_pc, next_pc, if2_pc, imem_write_addr;
  logic                       if2_v;
  logic                       imem_clear, imem_write_v, imem_hit, imem_fault;
  logic [`FE_INSTR_WIDTH-1:0] imem_write_instr, imem_instr;
  logic                       exception_v, fetch_fail;

  fe_controller u_controller
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_v_i(fe_cmd_v_i)
     ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
     ,.exception_v_i(exception_v)
     ,.fetch_fail_i(fetch_fail)
     ,.if2_pc_i(if2_pc)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     ,.redirect_v_o(redirect_v)
     ,.redirect_pc_o(redirect_pc)
     ,.advance_o(advance)
     ,.poison_o(poison)
     ,.block_o(block)
     ,.imem_clear_o(imem_clear)
     ,.imem_write_v_o(imem_write_v)
     ,.imem_write_addr_o(imem_write_addr)
     ,.imem_write_instr_o(imem_write_instr)
     );

  fe_pc_gen u_pc_gen
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.redirect_v_i(redirect_v)
     ,.redirect_pc_i(redirect_pc)
     ,.advance_i(advance)
     ,.poison_i(poison)
     ,.next_pc_o(next_pc)
     ,.if2_v_o(if2_v)
     ,.if2_pc_o(if2_pc)
     );

  fe_imem u_imem
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.read_pc_i(next_pc)
     ,.clear_i(imem_clear)
     ,.write_v_i(imem_write_v)
     ,.write_addr_i(imem_write_addr)
     ,.write_instr_i(imem_write_instr)
     ,.instr_o(imem_instr)
     ,.hit_o(imem_hit)
     ,.fault_o(imem_fault)
     );

  fe_queue_builder u_queue_builder
    (.if2_v_i(if2_v)
     ,.if2_pc_i(if2_pc)
     ,.instr_i(imem_instr)
     ,.hit_i(imem_hit)
     ,.fault_i(imem_fault)
     ,.block_i(block)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     ,.fe_queue_o(fe_queue_o)
     ,.fe_queue_v_o(fe_queue_v_o)
     ,.exception_v_o(exception_v)
     ,.fetch_fail_o(fetch_fail)
     );

  // Outside run the pipeline must already be drained by poison
  a_idle_pipe_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    (u_controller.state_r != e_run) |-> !if2_v)
    else $error("IF2 valid while controller not in run");

endmodule

/* tests/fe_golden.txt */
# C opcode vaddr instr   command (opcode 0 state reset, 1 redirect, 2 fill)
# M type pc payload      expected message (type 0 fetch, 1 exception; code 0 fault, 1 miss)
C 0 1000 00000000
M 1 1000 00000001
C 2 1000 00000013
M 0 1000 00000013
M 1 1004 00000001
C 2 1004 00100093
M 0 1004 00100093
M 1 1008 00000001
C 2 1008 00208113
M 0 1008 00208113
M 1 100c 00000001
C 1 1000 00000000
M 0 1000 00000013
M 0 1004 00100093
M 0 1008 00208113
M 1 100c 00000001
C 1 0ffc 00000000
M 1 0ffc 00000000
C 1 1100 00000000
M 1 1100 00000000
C 1 1002 00000000
M 1 1002 00000000
C 2 1100 deadbeef
M 1 1100 00000000
C 2 10fc 0000006f
M 0 10fc 0000006f
M 1 1100 00000000
C 0 1000 00000000
M 1 1000 00000001
C 1 1004 00000000
M 1 1004 00000001

/* tests/fe_tb_util.svh */
`ifndef FE_TB_UTIL_SVH
`define FE_TB_UTIL_SVH

// 8-bit Fibonacci LFSR, taps 8 6 5 4
function automatic logic [7:0] lfsr_step(input logic [7:0] state);
  logic feedback;
  feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
  return {state[6:0], feedback};
endfunction

// Ready is high about three cycles in four
task automatic draw_ready();
  logic [1:0] bits;
  lfsr_state = lfsr_step(lfsr_state);
  bits[0] = lfsr_state[0];
  lfsr_state = lfsr_step(lfsr_state);
  bits[1] = lfsr_state[0];
  fe_queue_ready_i = bits[0] | bits[1];
endtask

task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
  assert (got === exp)
  else
  begin
    value_errors++;
    $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic report_problem(input string what);
  other_errors++;
  $display("ERROR at %0t ns: %s", $time, what);
endtask

`endif

/* tests/tb_fe_top.sv */
`timescale 1ns/1ns

`include "fe_consts.svh"

module tb_fe_top;

  import fe_pkg::*;

  localparam int msg_timeout = 200;

  logic        clk_i = 1'b0;
  logic        reset_i;
  fe_cmd_s     fe_cmd_i;
  logic        fe_cmd_v_i;
  logic        fe_cmd_yumi_o;
  fe_queue_s   fe_queue_o;
  logic        fe_queue_v_o;
  logic        fe_queue_ready_i;

  logic [7:0]  lfsr_state;
  int          value_errors;
  int          other_errors;
  bit          aborted;

  // One entry per golden record of kind C or M
  logic [7:0]  rec_kind [$];
  logic [31:0] rec_a [$];
  logic [31:0] rec_b [$];
  logic [31:0] rec_c [$];

  `include "fe_tb_util.svh"

  fe_top u_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_v_i(fe_cmd_v_i)
     ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
     ,.fe_queue_o(fe_queue_o)
     ,.fe_queue_v_o(fe_queue_v_o)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     );

  always #10 clk_i = ~clk_i;

  task automatic load_golden();
    int              fd;
    int              n;
    logic [7:0]      kind;
    logic [31:0]     a, b, c;
    logic [8*128-1:0] skipped;
    fd = $fopen("tests/fe_golden.txt", "r");
    if (fd == 0)
    begin
      report_problem("cannot open tests/fe_golden.txt");
      aborted = 1'b1;
    end
    else
    begin
      n = $fscanf(fd, " %c", kind);
      while (n == 1)
      begin
        if (kind == "#")
          n = $fgets(skipped, fd);
        else
        begin
          n = $fscanf(fd, " %h %h %h", a, b, c);
          if (n != 3)
            report_problem("malformed record in golden file");
          rec_kind.push_back(kind);
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
        end
        n = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
      if (rec_kind.size() == 0)
      begin
        report_problem("golden file holds no records");
        aborted = 1'b1;
      end
    end
  endtask

  // Tasks below start and end 2 ns after a rising edge
  task automatic check_quiet(input int cycles);
    repeat (cycles)
    begin
      draw_ready();
      @(negedge clk_i);
      check_field("fe_queue_v_o", fe_queue_v_o, 0);
      check_field("fe_cmd_yumi_o", fe_cmd_yumi_o, 0);
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic issue_command(input int i);
    draw_ready();
    fe_cmd_i.opcode = fe_cmd_opcode_e'(rec_a[i][1:0]);
    fe_cmd_i.vaddr  = rec_b[i][`FE_VADDR_WIDTH-1:0];
    fe_cmd_i.instr  = rec_c[i];
    fe_cmd_v_i      = 1'b1;
    @(negedge clk_i);
    check_field("fe_cmd_yumi_o", fe_cmd_yumi_o, 1);
    check_field("fe_queue_v_o", fe_queue_v_o, 0);
    @(posedge clk_i);
    #2;
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic expect_message(input int i);
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < msg_timeout)
    begin
      draw_ready();
      @(negedge clk_i);
      if (fe_queue_v_o)
      begin
        seen = 1'b1;
        check_field("fe_queue_o.msg_type", fe_queue_o.msg_type, rec_a[i]);
        check_field("fe_queue_o.pc", fe_queue_o.pc, rec_b[i]);
        check_field("fe_queue_o.payload", fe_queue_o.payload, rec_c[i]);
      end
      @(posedge clk_i);
      #2;
      waited++;
    end
    assert (seen)
    else
    begin
      report_problem($sformatf("no queue message for pc %h within %0d cycles",
                               rec_b[i][15:0], msg_timeout));
      aborted = 1'b1;
    end
  endtask

  initial
  begin
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = 1'b0;
    lfsr_state       = 8'd39;
    value_errors     = 0;
    other_errors     = 0;
    aborted          = 1'b0;
    load_golden();
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    // Idle front end must not send anything
    check_quiet(20);
    for (int i = 0; i < rec_kind.size() && !aborted; i++)
    begin
      if (rec_kind[i] == "C")
      begin
        check_quiet(2);
        issue_command(i);
      end
      else
        expect_message(i);
    end
    check_quiet(4);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
